// File: design/router_stat_pkg.sv
/* Register map, bus types and port counts for the router statistics block.
   Word address is the byte address divided by four; counter order is pkt, byte, err, drop */
package router_stat_pkg;

    // Port counts
    localparam int ING_NUM_PORTS  = 4;
    localparam int EGR_NUM_PORTS  = 2;
    localparam int CNTRS_PER_PORT = 4;   // Packets, bytes, errors, drops

    // Bus types
    typedef logic [7:0]  bus_addr_t;     // Byte address
    typedef logic [31:0] bus_data_t;
    typedef logic [3:0]  bus_be_t;
    typedef logic [1:0]  bus_resp_t;

    localparam bus_resp_t RESP_OKAY        = 2'd0;
    localparam bus_resp_t RESP_SLAVE_ERROR = 2'd2;

    // Counter types
    typedef logic [15:0] pkt_len_t;
    typedef logic [31:0] ing_cnt_t;
    typedef logic [23:0] egr_cnt_t;      // Wraps at 24 bits, zero-extended on read
    typedef logic [31:0] drop_cnt_t;

    // Version word fields, packed major, minor, id from the top
    localparam logic [15:0] MODULE_ID     = 16'h5a17;
    localparam logic [7:0]  VERSION_MAJOR = 8'd1;
    localparam logic [7:0]  VERSION_MINOR = 8'd0;
    localparam bus_data_t   VERSION_WORD  = {VERSION_MAJOR, VERSION_MINOR, MODULE_ID};

    //////////////////////////////////////////////////////////////////////////////
    // Word addresses
    localparam int ADDR_VERSION_ID         = 0;
    localparam int ADDR_NUM_REGS           = 1;
    localparam int ADDR_SCRATCH            = 2;
    localparam int ADDR_ING_ENABLE_CON     = 3;
    localparam int ADDR_EGR_ENABLE_CON     = 4;
    localparam int ADDR_ING_STAT           = 5;
    localparam int ADDR_EGR_STAT           = 6;
    localparam int ADDR_ING_COUNTER_CON    = 7;
    localparam int ADDR_EGR_COUNTER_CON    = 8;
    localparam int ADDR_ING_COUNTERS_START = 9;
    localparam int ADDR_EGR_COUNTERS_START =
        ADDR_ING_COUNTERS_START + CNTRS_PER_PORT * ING_NUM_PORTS;
    localparam int TOTAL_REGS =
        ADDR_EGR_COUNTERS_START + CNTRS_PER_PORT * EGR_NUM_PORTS;

    // Counter register file, indexed from the ingress bank start
    localparam int CNT_REGS    = TOTAL_REGS - ADDR_ING_COUNTERS_START;
    localparam int EGR_CNT_OFS = ADDR_EGR_COUNTERS_START - ADDR_ING_COUNTERS_START;

endpackage

// File: design/port_stat_counters.sv
/* Per-port packet, byte and error counters; counts wrap at the width of cnt_t.
   A clear in the same cycle as a packet restarts the count with that packet */
`timescale 1ns/10ps

module port_stat_counters #(
    parameter int  num_ports = 4,
    parameter type cnt_t     = logic [31:0]
) (
    input  logic                     core_clk_ifc,
    input  logic                     peripheral_sresetn_core,
    input  logic [num_ports-1:0]     enable,
    input  logic [num_ports-1:0]     pkt_done,
    input  logic [num_ports-1:0]     pkt_err,
    input  logic [num_ports-1:0]     cnt_clear,
    input  router_stat_pkg::pkt_len_t pkt_len [num_ports],
    output cnt_t                     pkt_cnt  [num_ports],
    output cnt_t                     byte_cnt [num_ports],
    output cnt_t                     err_cnt  [num_ports]
);

    logic [num_ports-1:0] pkt_hit;       // Packet seen on an enabled port
    logic [num_ports-1:0] err_hit;

    assign pkt_hit = enable & pkt_done;
    assign err_hit = pkt_hit & pkt_err;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            for (int p = 0; p < num_ports; p++) begin
                pkt_cnt[p]  <= '0;
                byte_cnt[p] <= '0;
                err_cnt[p]  <= '0;
            end
        end else begin
            for (int p = 0; p < num_ports; p++) begin
                if (cnt_clear[p]) begin
                    // Restart from this cycle's packet, if any
                    pkt_cnt[p]  <= cnt_t'(pkt_hit[p]);
                    byte_cnt[p] <= pkt_hit[p] ? cnt_t'(pkt_len[p]) : '0;
                    err_cnt[p]  <= cnt_t'(err_hit[p]);
                end else if (pkt_hit[p]) begin
                    pkt_cnt[p]  <= pkt_cnt[p] + cnt_t'(1);
                    byte_cnt[p] <= byte_cnt[p] + cnt_t'(pkt_len[p]);   // Wraps
                    err_cnt[p]  <= err_cnt[p] + cnt_t'(pkt_err[p]);
                end
            end
        end
    end

endmodule

// File: design/router_stat_regs.sv
/* Single-word register block, one request per cycle, no back-pressure on responses.
   A counter-control bit must return to 0 before it can trigger the next snapshot */
`timescale 1ns/10ps

module router_stat_regs (
    input  logic                          core_clk_ifc,
    input  logic                          peripheral_sresetn_core,

    input  router_stat_pkg::bus_addr_t    address,
    input  logic                          write,
    input  router_stat_pkg::bus_data_t    writedata,
    input  router_stat_pkg::bus_be_t      byteenable,
    input  logic                          read,
    output logic                          waitrequest,
    output router_stat_pkg::bus_data_t    readdata,
    output logic                          readdatavalid,
    output logic                          writeresponsevalid,
    output router_stat_pkg::bus_resp_t    response,

    output logic [router_stat_pkg::ING_NUM_PORTS-1:0] ing_enable,
    output logic [router_stat_pkg::ING_NUM_PORTS-1:0] ing_clear,
    input  router_stat_pkg::ing_cnt_t     ing_pkt_cnt  [router_stat_pkg::ING_NUM_PORTS],
    input  router_stat_pkg::ing_cnt_t     ing_byte_cnt [router_stat_pkg::ING_NUM_PORTS],
    input  router_stat_pkg::ing_cnt_t     ing_err_cnt  [router_stat_pkg::ING_NUM_PORTS],
    input  logic [router_stat_pkg::ING_NUM_PORTS-1:0] ing_connected,
    input  logic [router_stat_pkg::ING_NUM_PORTS-1:0] ing_buf_full_drop,

    output logic [router_stat_pkg::EGR_NUM_PORTS-1:0] egr_enable,
    output logic [router_stat_pkg::EGR_NUM_PORTS-1:0] egr_clear,
    input  router_stat_pkg::egr_cnt_t     egr_pkt_cnt  [router_stat_pkg::EGR_NUM_PORTS],
    input  router_stat_pkg::egr_cnt_t     egr_byte_cnt [router_stat_pkg::EGR_NUM_PORTS],
    input  router_stat_pkg::egr_cnt_t     egr_err_cnt  [router_stat_pkg::EGR_NUM_PORTS],
    input  logic [router_stat_pkg::EGR_NUM_PORTS-1:0] egr_connected,
    input  logic [router_stat_pkg::EGR_NUM_PORTS-1:0] egr_buf_full_drop
);

    import router_stat_pkg::*;

    logic [5:0] word_addr;
    logic       wr_acc;
    logic       rd_acc;
    logic       addr_bad;
    bus_data_t  rd_data;                 // Current value at word_addr
    bus_data_t  wr_merged;
    bus_data_t  scratch;

    logic [ING_NUM_PORTS-1:0] ing_enable_con, ing_cnt_con, ing_stat;
    logic [ING_NUM_PORTS-1:0] ing_sample, ing_sample_d;
    logic [EGR_NUM_PORTS-1:0] egr_enable_con, egr_cnt_con, egr_stat;
    logic [EGR_NUM_PORTS-1:0] egr_sample, egr_sample_d;

    bus_data_t cnt_regs     [CNT_REGS];  // Snapshot registers, both banks
    drop_cnt_t ing_drop_cnt [ING_NUM_PORTS];
    drop_cnt_t egr_drop_cnt [EGR_NUM_PORTS];

    function automatic bus_data_t lane_merge(bus_data_t old_word, bus_data_t new_word,
                                             bus_be_t be);
        bus_data_t merged;
        merged = old_word;
        for (int b = 0; b < $bits(bus_be_t); b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Bus decode

    assign word_addr = address[7:2];
    assign wr_acc    = write & ~waitrequest;
    assign rd_acc    = read & ~waitrequest;
    assign addr_bad  = word_addr >= TOTAL_REGS;
    assign wr_merged = lane_merge(rd_data, writedata, byteenable);

    always_comb begin
        rd_data = '0;                    // Undefined words read as zero
        case (word_addr)
            ADDR_VERSION_ID:      rd_data = VERSION_WORD;
            ADDR_NUM_REGS:        rd_data = bus_data_t'(TOTAL_REGS);
            ADDR_SCRATCH:         rd_data = scratch;
            ADDR_ING_ENABLE_CON:  rd_data = bus_data_t'(ing_enable_con);
            ADDR_EGR_ENABLE_CON:  rd_data = bus_data_t'(egr_enable_con);
            ADDR_ING_STAT:        rd_data = bus_data_t'(ing_stat);
            ADDR_EGR_STAT:        rd_data = bus_data_t'(egr_stat);
            ADDR_ING_COUNTER_CON: rd_data = bus_data_t'(ing_cnt_con);
            ADDR_EGR_COUNTER_CON: rd_data = bus_data_t'(egr_cnt_con);
            default: begin
                if (!addr_bad) begin
                    rd_data = cnt_regs[word_addr - ADDR_ING_COUNTERS_START];
                end
            end
        endcase
    end

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            waitrequest        <= 1'b1;
            readdatavalid      <= 1'b0;
            writeresponsevalid <= 1'b0;
        end else begin
            waitrequest        <= 1'b0;
            readdatavalid      <= rd_acc;
            writeresponsevalid <= wr_acc;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (wr_acc | rd_acc) begin
            response <= addr_bad ? RESP_SLAVE_ERROR : RESP_OKAY;
        end
        if (rd_acc) begin
            readdata <= rd_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Writable registers

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            scratch        <= '0;
            ing_enable_con <= '1;
            egr_enable_con <= '1;
            ing_cnt_con    <= '0;
            egr_cnt_con    <= '0;
        end else if (wr_acc) begin
            case (word_addr)
                ADDR_SCRATCH:         scratch        <= wr_merged;
                ADDR_ING_ENABLE_CON:  ing_enable_con <= wr_merged[ING_NUM_PORTS-1:0];
                ADDR_EGR_ENABLE_CON:  egr_enable_con <= wr_merged[EGR_NUM_PORTS-1:0];
                ADDR_ING_COUNTER_CON: ing_cnt_con    <= wr_merged[ING_NUM_PORTS-1:0];
                ADDR_EGR_COUNTER_CON: egr_cnt_con    <= wr_merged[EGR_NUM_PORTS-1:0];
                default: ;                       // Read-only or undefined
            endcase
        end
    end

    // Enables, status and snapshot request pipeline
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            ing_enable   <= '1;
            egr_enable   <= '1;
            ing_stat     <= '0;
            egr_stat     <= '0;
            ing_sample   <= '0;
            ing_sample_d <= '0;
            egr_sample   <= '0;
            egr_sample_d <= '0;
        end else begin
            ing_enable   <= ing_enable_con;
            egr_enable   <= egr_enable_con;
            ing_stat     <= ing_connected;
            egr_stat     <= egr_connected;
            ing_sample   <= ing_cnt_con;
            ing_sample_d <= ing_sample;
            egr_sample   <= egr_cnt_con;
            egr_sample_d <= egr_sample;
        end
    end

    // Rising edge of the sampled control bit, counters clear on the snapshot edge
    assign ing_clear = ing_sample & ~ing_sample_d;
    assign egr_clear = egr_sample & ~egr_sample_d;

    ////////////////////////////////////////////////////////////////////////////
    // Snapshot and drop counting

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            for (int i = 0; i < CNT_REGS; i++) begin
                cnt_regs[i] <= '0;
            end
            for (int p = 0; p < ING_NUM_PORTS; p++) begin
                ing_drop_cnt[p] <= '0;
            end
            for (int p = 0; p < EGR_NUM_PORTS; p++) begin
                egr_drop_cnt[p] <= '0;
            end
        end else begin
            for (int p = 0; p < ING_NUM_PORTS; p++) begin
                if (ing_clear[p]) begin
                    cnt_regs[CNTRS_PER_PORT*p]     <= ing_pkt_cnt[p];
                    cnt_regs[CNTRS_PER_PORT*p + 1] <= ing_byte_cnt[p];
                    cnt_regs[CNTRS_PER_PORT*p + 2] <= ing_err_cnt[p];
                    cnt_regs[CNTRS_PER_PORT*p + 3] <= ing_drop_cnt[p];
                    ing_drop_cnt[p] <= drop_cnt_t'(ing_buf_full_drop[p]);
                end else if (ing_buf_full_drop[p]) begin   // Counted even when disabled
                    ing_drop_cnt[p] <= ing_drop_cnt[p] + drop_cnt_t'(1);
                end
            end
            for (int p = 0; p < EGR_NUM_PORTS; p++) begin
                if (egr_clear[p]) begin
                    cnt_regs[EGR_CNT_OFS + CNTRS_PER_PORT*p]     <= bus_data_t'(egr_pkt_cnt[p]);
                    cnt_regs[EGR_CNT_OFS + CNTRS_PER_PORT*p + 1] <= bus_data_t'(egr_byte_cnt[p]);
                    cnt_regs[EGR_CNT_OFS + CNTRS_PER_PORT*p + 2] <= bus_data_t'(egr_err_cnt[p]);
                    cnt_regs[EGR_CNT_OFS + CNTRS_PER_PORT*p + 3] <= egr_drop_cnt[p];
                    egr_drop_cnt[p] <= drop_cnt_t'(egr_buf_full_drop[p]);
                end else if (egr_buf_full_drop[p]) begin
                    egr_drop_cnt[p] <= egr_drop_cnt[p] + drop_cnt_t'(1);
                end
            end
        end
    end

endmodule

// File: design/router_stat_top.sv
/* Router statistics top: ingress and egress counter banks behind one register block.
   Single clock and reset; port strobes are one cycle wide */
`timescale 1ns/10ps

module router_stat_top (
    input  logic                          core_clk_ifc,
    input  logic                          peripheral_sresetn_core,

    input  router_stat_pkg::bus_addr_t    address,
    input  logic                          write,
    input  router_stat_pkg::bus_data_t    writedata,
    input  router_stat_pkg::bus_be_t      byteenable,
    input  logic                          read,
    output logic                          waitrequest,
    output router_stat_pkg::bus_data_t    readdata,
    output logic                          readdatavalid,
    output logic                          writeresponsevalid,
    output router_stat_pkg::bus_resp_t    response,

    input  logic [router_stat_pkg::ING_NUM_PORTS-1:0] ing_pkt_done,
    input  router_stat_pkg::pkt_len_t     ing_pkt_len [router_stat_pkg::ING_NUM_PORTS],
    input  logic [router_stat_pkg::ING_NUM_PORTS-1:0] ing_pkt_err,
    input  logic [router_stat_pkg::ING_NUM_PORTS-1:0] ing_connected,
    input  logic [router_stat_pkg::ING_NUM_PORTS-1:0] ing_buf_full_drop,

    input  logic [router_stat_pkg::EGR_NUM_PORTS-1:0] egr_pkt_done,
    input  router_stat_pkg::pkt_len_t     egr_pkt_len [router_stat_pkg::EGR_NUM_PORTS],
    input  logic [router_stat_pkg::EGR_NUM_PORTS-1:0] egr_pkt_err,
    input  logic [router_stat_pkg::EGR_NUM_PORTS-1:0] egr_connected,
    input  logic [router_stat_pkg::EGR_NUM_PORTS-1:0] egr_buf_full_drop
);

    import router_stat_pkg::*;

    logic [ING_NUM_PORTS-1:0] ing_enable, ing_clear;
    logic [EGR_NUM_PORTS-1:0] egr_enable, egr_clear;

    ing_cnt_t ing_pkt_cnt [ING_NUM_PORTS];
    ing_cnt_t ing_byte_cnt [ING_NUM_PORTS];
    ing_cnt_t ing_err_cnt [ING_NUM_PORTS];
    egr_cnt_t egr_pkt_cnt [EGR_NUM_PORTS];
    egr_cnt_t egr_byte_cnt [EGR_NUM_PORTS];
    egr_cnt_t egr_err_cnt [EGR_NUM_PORTS];

    port_stat_counters #(
        .num_ports (ING_NUM_PORTS),
        .cnt_t     (ing_cnt_t)
    ) i_ing_counters (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .enable                  (ing_enable),
        .pkt_done                (ing_pkt_done),
        .pkt_err                 (ing_pkt_err),
        .cnt_clear               (ing_clear),
        .pkt_len                 (ing_pkt_len),
        .pkt_cnt                 (ing_pkt_cnt),
        .byte_cnt                (ing_byte_cnt),
        .err_cnt                 (ing_err_cnt)
    );

    port_stat_counters #(
        .num_ports (EGR_NUM_PORTS),
        .cnt_t     (egr_cnt_t)               // 24-bit egress counters
    ) i_egr_counters (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .enable                  (egr_enable),
        .pkt_done                (egr_pkt_done),
        .pkt_err                 (egr_pkt_err),
        .cnt_clear               (egr_clear),
        .pkt_len                 (egr_pkt_len),
        .pkt_cnt                 (egr_pkt_cnt),
        .byte_cnt                (egr_byte_cnt),
        .err_cnt                 (egr_err_cnt)
    );

    router_stat_regs i_regs (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .address                 (address),
        .write                   (write),
        .writedata               (writedata),
        .byteenable              (byteenable),
        .read                    (read),
        .waitrequest             (waitrequest),
        .readdata                (readdata),
        .readdatavalid           (readdatavalid),
        .writeresponsevalid      (writeresponsevalid),
        .response                (response),
        .ing_enable              (ing_enable),
        .ing_clear               (ing_clear),
        .ing_pkt_cnt             (ing_pkt_cnt),
        .ing_byte_cnt            (ing_byte_cnt),
        .ing_err_cnt             (ing_err_cnt),
        .ing_connected           (ing_connected),
        .ing_buf_full_drop       (ing_buf_full_drop),
        .egr_enable              (egr_enable),
        .egr_clear               (egr_clear),
        .egr_pkt_cnt             (egr_pkt_cnt),
        .egr_byte_cnt            (egr_byte_cnt),
        .egr_err_cnt             (egr_err_cnt),
        .egr_connected           (egr_connected),
        .egr_buf_full_drop       (egr_buf_full_drop)
    );

endmodule

// File: bench/router_stat_model.sv
/* Reference totals for the statistics block; enable masks come straight from the testbench.
   Totals restart at any clock edge where clear_totals is high */
`timescale 1ns/10ps

module router_stat_model (
    input  logic                                      core_clk_ifc,
    input  logic                                      peripheral_sresetn_core,
    input  logic                                      clear_totals,
    input  logic [router_stat_pkg::ING_NUM_PORTS-1:0] ing_mask,
    input  logic [router_stat_pkg::ING_NUM_PORTS-1:0] ing_pkt_done,
    input  router_stat_pkg::pkt_len_t                 ing_pkt_len [router_stat_pkg::ING_NUM_PORTS],
    input  logic [router_stat_pkg::ING_NUM_PORTS-1:0] ing_pkt_err,
    input  logic [router_stat_pkg::ING_NUM_PORTS-1:0] ing_buf_full_drop,
    input  logic [router_stat_pkg::EGR_NUM_PORTS-1:0] egr_mask,
    input  logic [router_stat_pkg::EGR_NUM_PORTS-1:0] egr_pkt_done,
    input  router_stat_pkg::pkt_len_t                 egr_pkt_len [router_stat_pkg::EGR_NUM_PORTS],
    input  logic [router_stat_pkg::EGR_NUM_PORTS-1:0] egr_pkt_err,
    input  logic [router_stat_pkg::EGR_NUM_PORTS-1:0] egr_buf_full_drop
);

    import router_stat_pkg::*;

    ing_cnt_t  ing_pkt_tot  [ING_NUM_PORTS];
    ing_cnt_t  ing_byte_tot [ING_NUM_PORTS];
    ing_cnt_t  ing_err_tot  [ING_NUM_PORTS];
    drop_cnt_t ing_drop_tot [ING_NUM_PORTS];
    egr_cnt_t  egr_pkt_tot  [EGR_NUM_PORTS];
    egr_cnt_t  egr_byte_tot [EGR_NUM_PORTS];   // 24-bit, wraps like the egress bank
    egr_cnt_t  egr_err_tot  [EGR_NUM_PORTS];
    drop_cnt_t egr_drop_tot [EGR_NUM_PORTS];

    always @(posedge core_clk_ifc) begin
        for (int p = 0; p < ING_NUM_PORTS; p++) begin
            if (!peripheral_sresetn_core || clear_totals) begin
                ing_pkt_tot[p]  <= '0;
                ing_byte_tot[p] <= '0;
                ing_err_tot[p]  <= '0;
                ing_drop_tot[p] <= '0;
            end else begin
                if (ing_pkt_done[p] && ing_mask[p]) begin
                    ing_pkt_tot[p]  <= ing_pkt_tot[p] + 1'b1;
                    ing_byte_tot[p] <= ing_byte_tot[p] + ing_cnt_t'(ing_pkt_len[p]);
                    ing_err_tot[p]  <= ing_err_tot[p] + ing_cnt_t'(ing_pkt_err[p]);
                end
                ing_drop_tot[p] <= ing_drop_tot[p] + drop_cnt_t'(ing_buf_full_drop[p]);
            end
        end
        for (int p = 0; p < EGR_NUM_PORTS; p++) begin
            if (!peripheral_sresetn_core || clear_totals) begin
                egr_pkt_tot[p]  <= '0;
                egr_byte_tot[p] <= '0;
                egr_err_tot[p]  <= '0;
                egr_drop_tot[p] <= '0;
            end else begin
                if (egr_pkt_done[p] && egr_mask[p]) begin
                    egr_pkt_tot[p]  <= egr_pkt_tot[p] + 1'b1;
                    egr_byte_tot[p] <= egr_byte_tot[p] + egr_cnt_t'(egr_pkt_len[p]);
                    egr_err_tot[p]  <= egr_err_tot[p] + egr_cnt_t'(egr_pkt_err[p]);
                end
                egr_drop_tot[p] <= egr_drop_tot[p] + drop_cnt_t'(egr_buf_full_drop[p]);
            end
        end
    end

endmodule

// File: bench/router_stat_tb.sv
/* Random traffic testbench for router_stat_top checked against router_stat_model.
   Snapshots are only requested after the port inputs have been idle for 4 cycles */
`timescale 1ns/10ps

module router_stat_tb;

    import router_stat_pkg::*;

    localparam int        PHASE_CYCLES   = 1000;
    localparam int        TIMEOUT_CYCLES = 2 * (3 * PHASE_CYCLES + 200 * 6 + 300);
    localparam bus_data_t ING_ALL        = bus_data_t'((1 << ING_NUM_PORTS) - 1);
    localparam bus_data_t EGR_ALL        = bus_data_t'((1 << EGR_NUM_PORTS) - 1);

    logic       core_clk_ifc = 1'b0;
    logic       peripheral_sresetn_core;
    bus_addr_t  address;
    logic       write, read, waitrequest, readdatavalid, writeresponsevalid, clear_totals;
    bus_data_t  writedata, readdata;
    bus_be_t    byteenable;
    bus_resp_t  response;
    logic [ING_NUM_PORTS-1:0] ing_pkt_done, ing_pkt_err, ing_connected, ing_buf_full_drop;
    logic [ING_NUM_PORTS-1:0] ing_mask;
    logic [EGR_NUM_PORTS-1:0] egr_pkt_done, egr_pkt_err, egr_connected, egr_buf_full_drop;
    logic [EGR_NUM_PORTS-1:0] egr_mask;
    pkt_len_t   ing_pkt_len [ING_NUM_PORTS];
    pkt_len_t   egr_pkt_len [EGR_NUM_PORTS];
    integer     seed   = 32'hefcb_dc5a;
    int         cycles = 0;

    router_stat_top   i_dut   (.*);
    router_stat_model i_model (.*);      // Same stimulus plus the masks written by the bench

    always #4 core_clk_ifc = ~core_clk_ifc;

    always @(posedge core_clk_ifc) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks and bus access

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_resp(input string name, input bus_resp_t got, input bus_resp_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    function automatic bus_data_t apply_byteenable(bus_data_t old_word, bus_data_t new_word,
                                                   bus_be_t be);
        bus_data_t lanes;
        for (int b = 0; b < $bits(bus_be_t); b++) begin
            lanes[8*b +: 8] = {8{be[b]}};
        end
        return (old_word & ~lanes) | (new_word & lanes);
    endfunction

    // One request driven on a falling edge and its response awaited on later falling edges
    task automatic bus_access(input int word, input logic is_write, input bus_data_t data,
                              input bus_be_t be, output bus_data_t rdata, output bus_resp_t resp);
        int waited;
        @(negedge core_clk_ifc);
        if (waitrequest || readdatavalid || writeresponsevalid) begin
            fail_run($sformatf("Bus not idle before the request to word %0d", word));
        end
        address    = bus_addr_t'(word << 2);
        write      = is_write;
        read       = !is_write;
        writedata  = data;
        byteenable = be;
        @(negedge core_clk_ifc);
        write  = 1'b0;
        read   = 1'b0;
        waited = 1;
        while (!(is_write ? writeresponsevalid : readdatavalid)) begin
            if (waited >= 4) begin
                fail_run($sformatf("No bus response within 4 cycles for word %0d", word));
            end else begin
                @(negedge core_clk_ifc);
                waited++;
            end
        end
        rdata = readdata;
        resp  = response;
    endtask

    task automatic write_check(input int word, input bus_data_t data, input bus_be_t be,
                               input bus_resp_t exp_resp);
        bus_data_t rdata;
        bus_resp_t resp;
        bus_access(word, 1'b1, data, be, rdata, resp);
        check_resp($sformatf("response of write to word %0d", word), resp, exp_resp);
    endtask

    task automatic read_check(input int word, input bus_data_t exp_data,
                              input bus_resp_t exp_resp, input string name);
        bus_data_t rdata;
        bus_resp_t resp;
        bus_access(word, 1'b0, '0, '0, rdata, resp);
        check_data(name, rdata, exp_data);
        check_resp({name, " response"}, resp, exp_resp);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Traffic and snapshots

    task automatic run_traffic(input int num_cycles);
        repeat (num_cycles) begin
            @(negedge core_clk_ifc);
            for (int p = 0; p < ING_NUM_PORTS; p++) begin
                ing_pkt_done[p]      = ($random(seed) & 3) == 0;
                ing_pkt_len[p]       = pkt_len_t'($random(seed));
                ing_pkt_err[p]       = 1'($random(seed));
                ing_buf_full_drop[p] = ($random(seed) & 7) == 0;
            end
            for (int p = 0; p < EGR_NUM_PORTS; p++) begin
                egr_pkt_done[p]      = ($random(seed) & 3) != 0;   // Dense enough for bytes to wrap
                egr_pkt_len[p]       = pkt_len_t'($random(seed));
                egr_pkt_err[p]       = 1'($random(seed));
                egr_buf_full_drop[p] = ($random(seed) & 7) == 0;
            end
        end
        @(negedge core_clk_ifc);
        ing_pkt_done      = '0;
        ing_buf_full_drop = '0;
        egr_pkt_done      = '0;
        egr_buf_full_drop = '0;
        repeat (4) @(negedge core_clk_ifc);
    endtask

    task automatic snapshot_check();
        string     kind [CNTRS_PER_PORT] = '{"pkt", "byte", "err", "drop"};
        bus_data_t exp_vals [CNTRS_PER_PORT];
        write_check(ADDR_ING_COUNTER_CON, ING_ALL, 4'hf, RESP_OKAY);
        write_check(ADDR_EGR_COUNTER_CON, EGR_ALL, 4'hf, RESP_OKAY);
        repeat (3) @(negedge core_clk_ifc);
        write_check(ADDR_ING_COUNTER_CON, '0, 4'hf, RESP_OKAY);   // Re-arm for next snapshot
        write_check(ADDR_EGR_COUNTER_CON, '0, 4'hf, RESP_OKAY);
        for (int p = 0; p < ING_NUM_PORTS; p++) begin
            exp_vals = '{i_model.ing_pkt_tot[p], i_model.ing_byte_tot[p],
                         i_model.ing_err_tot[p], i_model.ing_drop_tot[p]};
            for (int k = 0; k < CNTRS_PER_PORT; k++) begin
                read_check(ADDR_ING_COUNTERS_START + CNTRS_PER_PORT*p + k, exp_vals[k],
                           RESP_OKAY, $sformatf("ing port %0d %s count", p, kind[k]));
            end
        end
        for (int p = 0; p < EGR_NUM_PORTS; p++) begin
            exp_vals = '{bus_data_t'(i_model.egr_pkt_tot[p]), bus_data_t'(i_model.egr_byte_tot[p]),
                         bus_data_t'(i_model.egr_err_tot[p]), i_model.egr_drop_tot[p]};
            for (int k = 0; k < CNTRS_PER_PORT; k++) begin
                read_check(ADDR_EGR_COUNTERS_START + CNTRS_PER_PORT*p + k, exp_vals[k],
                           RESP_OKAY, $sformatf("egr port %0d %s count", p, kind[k]));
            end
        end
        read_check(ADDR_ING_STAT, bus_data_t'(ing_connected), RESP_OKAY, "ing status");
        read_check(ADDR_EGR_STAT, bus_data_t'(egr_connected), RESP_OKAY, "egr status");
        @(negedge core_clk_ifc);
        clear_totals = 1'b1;
        @(negedge core_clk_ifc);
        clear_totals = 1'b0;
    endtask

    task automatic traffic_phase();
        ing_mask      = ING_NUM_PORTS'($random(seed));
        egr_mask      = EGR_NUM_PORTS'($random(seed));
        ing_connected = ING_NUM_PORTS'($random(seed));    // Held for the whole phase
        egr_connected = EGR_NUM_PORTS'($random(seed));
        write_check(ADDR_ING_ENABLE_CON, bus_data_t'(ing_mask), 4'hf, RESP_OKAY);
        write_check(ADDR_EGR_ENABLE_CON, bus_data_t'(egr_mask), 4'hf, RESP_OKAY);
        repeat (2) @(negedge core_clk_ifc);
        run_traffic(PHASE_CYCLES);
        snapshot_check();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        int        word;
        bus_data_t data;
        bus_be_t   be;
        bus_data_t exp_reg [ADDR_EGR_COUNTER_CON+1];
        bus_data_t wmask   [ADDR_EGR_COUNTER_CON+1];

        // Words 0 to 8 in address order
        exp_reg = '{{VERSION_MAJOR, VERSION_MINOR, MODULE_ID}, 32'd33, '0, ING_ALL, EGR_ALL,
                    '0, '0, '0, '0};
        wmask   = '{'0, '0, '1, ING_ALL, EGR_ALL, '0, '0, ING_ALL, EGR_ALL};
        peripheral_sresetn_core = 1'b0;
        {address, write, read, writedata, byteenable, clear_totals} = '0;
        {ing_pkt_done, ing_pkt_err, ing_connected, ing_buf_full_drop} = '0;
        {egr_pkt_done, egr_pkt_err, egr_connected, egr_buf_full_drop} = '0;
        ing_pkt_len = '{default: '0};
        egr_pkt_len = '{default: '0};
        ing_mask    = ING_NUM_PORTS'(ING_ALL);
        egr_mask    = EGR_NUM_PORTS'(EGR_ALL);
        repeat (5) @(posedge core_clk_ifc);
        @(negedge core_clk_ifc);
        if (waitrequest !== 1'b1) begin
            fail_run("waitrequest was not high during reset");
        end
        peripheral_sresetn_core = 1'b1;
        while (waitrequest) @(negedge core_clk_ifc);

        for (int a = 0; a <= ADDR_EGR_COUNTER_CON; a++) begin
            read_check(a, exp_reg[a], RESP_OKAY, $sformatf("reset value of word %0d", a));
        end
        for (int a = ADDR_ING_COUNTERS_START; a < TOTAL_REGS; a++) begin
            read_check(a, '0, RESP_OKAY, $sformatf("reset counter word %0d", a));
        end

        // Every read-only word keeps its value under a full-width write
        for (int a = 0; a <= ADDR_EGR_COUNTER_CON; a++) begin
            if (wmask[a] == '0) begin
                write_check(a, ~exp_reg[a], 4'hf, RESP_OKAY);
                read_check(a, exp_reg[a], RESP_OKAY, $sformatf("read-only word %0d", a));
            end
        end

        // Byte-lane writes that leave read-only words unchanged
        repeat (16) begin
            word = int'($unsigned($random(seed)) % (ADDR_EGR_COUNTER_CON + 1));
            data = $random(seed);
            be   = bus_be_t'($random(seed));
            exp_reg[word] = (exp_reg[word] & ~wmask[word]) |
                            (apply_byteenable(exp_reg[word], data, be) & wmask[word]);
            write_check(word, data, be, RESP_OKAY);
            read_check(word, exp_reg[word], RESP_OKAY, $sformatf("word %0d after write", word));
        end
        write_check(ADDR_ING_COUNTER_CON, '0, 4'hf, RESP_OKAY);
        write_check(ADDR_EGR_COUNTER_CON, '0, 4'hf, RESP_OKAY);

        repeat (12) begin
            word = TOTAL_REGS + int'($unsigned($random(seed)) % (64 - TOTAL_REGS));
            write_check(word, $random(seed), bus_be_t'($random(seed)), RESP_SLAVE_ERROR);
            read_check(word, '0, RESP_SLAVE_ERROR, $sformatf("undefined word %0d", word));
        end

        repeat (3) traffic_phase();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: list.f
design/router_stat_pkg.sv
design/port_stat_counters.sv
design/router_stat_regs.sv
design/router_stat_top.sv
bench/router_stat_model.sv
bench/router_stat_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the router statistics testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module router_stat_tb -o router_stat_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/router_stat_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1
